// ==== design/bram_store.sv ====
////////////////////////////////////////////////////////////
// word RAM, addresses wrap at BRAM_WORDS
// a write replies with the word it replaced
////////////////////////////////////////////////////////////
`include "soc_settings.svh"

module bram_store (
    input  logic      clk,
    mem_bus_if.device bus
);

    localparam int AW = $clog2(`BRAM_WORDS);

    soc_pkg::word_t mem [`BRAM_WORDS];
    logic [AW-1:0]  idx;

    assign idx = bus.addr[AW+1:2];

    // ready follows valid, which the decoder holds low in reset
    always_ff @(posedge clk) begin
        bus.ready <= bus.valid;
        if (bus.valid) begin
            bus.rdata <= mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (bus.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    a_no_valid_in_reply : assert property (@(posedge clk) !(bus.valid && bus.ready));

endmodule

// ==== design/bus_decoder.sv ====
////////////////////////////////////////////////////////////
// routes one host request to one device and merges replies
// unmapped addresses reply zero with an access fault
////////////////////////////////////////////////////////////
`include "soc_settings.svh"

module bus_decoder (
    input  logic           clk,
    input  logic           resetn,
    input  logic           mem_valid,
    input  soc_pkg::word_t mem_addr,
    input  soc_pkg::word_t mem_wdata,
    input  soc_pkg::strb_t mem_wstrb,
    output logic           mem_ready,
    output soc_pkg::word_t mem_rdata,
    output logic           access_fault,
    mem_bus_if.host        bram_bus,
    mem_bus_if.host        uart_bus,
    mem_bus_if.host        timer_bus
);

    soc_pkg::dev_sel_e sel;
    logic              self_valid;
    logic              self_ready;
    logic              self_fault;
    soc_pkg::word_t    self_rdata;

    //////////////////////////////////////////////////////////
    // address classification
    always_comb begin
        if (mem_addr < 32'(`BRAM_WORDS * 4)) begin
            sel = soc_pkg::DEV_BRAM;
        end else if (mem_addr == `UART_TX_ADDR || mem_addr == `UART_RX_ADDR ||
                     mem_addr == `UART_LSR_ADDR) begin
            sel = soc_pkg::DEV_UART;
        end else if ((mem_addr & ~32'hf) == `TIMER_BASE) begin
            sel = soc_pkg::DEV_TIMER;
        end else if (mem_addr == `CPU_FREQ_ADDR) begin
            sel = soc_pkg::DEV_FREQ;
        end else begin
            sel = soc_pkg::DEV_NONE;
        end
    end

    // a device's own ready blocks a second cycle of the held request
    assign bram_bus.valid  = mem_valid && sel == soc_pkg::DEV_BRAM && !bram_bus.ready;
    assign uart_bus.valid  = mem_valid && sel == soc_pkg::DEV_UART && !uart_bus.ready;
    assign timer_bus.valid = mem_valid && sel == soc_pkg::DEV_TIMER && !timer_bus.ready;

    assign bram_bus.addr   = mem_addr;
    assign bram_bus.wdata  = mem_wdata;
    assign bram_bus.wstrb  = mem_wstrb;
    assign uart_bus.addr   = mem_addr;
    assign uart_bus.wdata  = mem_wdata;
    assign uart_bus.wstrb  = mem_wstrb;
    assign timer_bus.addr  = mem_addr;
    assign timer_bus.wdata = mem_wdata;
    assign timer_bus.wstrb = mem_wstrb;

    //////////////////////////////////////////////////////////
    // local reply for the frequency register and unmapped space
    assign self_valid = mem_valid && !self_ready &&
                        (sel == soc_pkg::DEV_FREQ || sel == soc_pkg::DEV_NONE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            self_ready <= 1'b0;
            self_fault <= 1'b0;
        end else begin
            self_ready <= self_valid;
            self_fault <= self_valid && sel == soc_pkg::DEV_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (self_valid) begin
            self_rdata <= (sel == soc_pkg::DEV_FREQ) ? `SYSTEM_CLK : '0;
        end
    end

    //////////////////////////////////////////////////////////
    // reply merge
    assign mem_ready    = bram_bus.ready | uart_bus.ready | timer_bus.ready | self_ready;
    // fault is only ever set together with the local ready
    assign access_fault = self_fault;

    always_comb begin
        if (bram_bus.ready) begin
            mem_rdata = bram_bus.rdata;
        end else if (uart_bus.ready) begin
            mem_rdata = uart_bus.rdata;
        end else if (timer_bus.ready) begin
            mem_rdata = timer_bus.rdata;
        end else if (self_ready) begin
            mem_rdata = self_rdata;
        end else begin
            mem_rdata = '0;
        end
    end

    // the devices never reply together
    a_one_reply : assert property (@(posedge clk) disable iff (!resetn)
        $onehot0({bram_bus.ready, uart_bus.ready, timer_bus.ready, self_ready}));

endmodule

// ==== design/core_timer.sv ====
////////////////////////////////////////////////////////////
// machine timer, mtime is read only and mtimecmp read/write
// irq is a level while mtime >= mtimecmp
////////////////////////////////////////////////////////////
`include "soc_settings.svh"

module core_timer (
    input  logic      clk,
    input  logic      resetn,
    mem_bus_if.device bus,
    output logic      irq
);

    localparam int PW = $clog2(`TICK_DIV);

    logic [PW-1:0] prescale;
    logic [63:0]   mtime;
    logic [63:0]   mtimecmp;
    logic [1:0]    off;
    logic          wr;

    // +0 mtime lo, +4 mtime hi, +8 cmp lo, +12 cmp hi
    assign off = bus.addr[3:2];
    assign wr  = bus.valid && |bus.wstrb;
    assign irq = mtime >= mtimecmp;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prescale <= '0;
            mtime    <= '0;
        end else if (prescale == PW'(`TICK_DIV - 1)) begin
            prescale <= '0;
            mtime    <= mtime + 64'd1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mtimecmp <= '1;
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= bus.valid;
            if (wr && off[1]) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.wstrb[b]) begin
                        mtimecmp[32*off[0] + 8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.valid) begin
            case (off)
                2'd0:    bus.rdata <= mtime[31:0];
                2'd1:    bus.rdata <= mtime[63:32];
                2'd2:    bus.rdata <= mtimecmp[31:0];
                default: bus.rdata <= mtimecmp[63:32];
            endcase
        end
    end

endmodule

// ==== design/mem_bus_if.sv ====
////////////////////////////////////////////////////////////
// valid/ready word bus, reply one cycle after valid
////////////////////////////////////////////////////////////
interface mem_bus_if;

    logic           valid;
    logic           ready;
    soc_pkg::word_t addr;
    soc_pkg::word_t wdata;
    soc_pkg::strb_t wstrb;
    soc_pkg::word_t rdata;

    // decoder side
    modport host (
        output valid, addr, wdata, wstrb,
        input  ready, rdata
    );

    // peripheral side
    modport device (
        input  valid, addr, wdata, wstrb,
        output ready, rdata
    );

endinterface

// ==== design/soc_io_top.sv ====
////////////////////////////////////////////////////////////
// device side of the SoC, one host on plain ports
// every access replies one cycle after valid
////////////////////////////////////////////////////////////
`include "soc_settings.svh"

module soc_io_top (
    input  logic           clk,
    input  logic           resetn,
    input  logic           mem_valid,
    input  soc_pkg::word_t mem_addr,
    input  soc_pkg::word_t mem_wdata,
    input  soc_pkg::strb_t mem_wstrb,
    output logic           mem_ready,
    output soc_pkg::word_t mem_rdata,
    output logic           access_fault,
    input  logic           uart_rx,
    output logic           uart_tx,
    output logic           timer_irq
);

    mem_bus_if bram_bus ();
    mem_bus_if uart_bus ();
    mem_bus_if timer_bus ();

    bus_decoder u_decoder (
        .clk         (clk),
        .resetn      (resetn),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .access_fault(access_fault),
        .bram_bus    (bram_bus),
        .uart_bus    (uart_bus),
        .timer_bus   (timer_bus)
    );

    bram_store u_bram (
        .clk(clk),
        .bus(bram_bus)
    );

    uart_port u_uart (
        .clk    (clk),
        .resetn (resetn),
        .bus    (uart_bus),
        .uart_rx(uart_rx),
        .uart_tx(uart_tx)
    );

    core_timer u_timer (
        .clk   (clk),
        .resetn(resetn),
        .bus   (timer_bus),
        .irq   (timer_irq)
    );

endmodule

// ==== design/soc_pkg.sv ====
////////////////////////////////////////////////////////////
// bus word types and device select codes
////////////////////////////////////////////////////////////
package soc_pkg;

    // data word and byte address
    typedef logic [31:0] word_t;

    // byte write strobes, all zero is a read
    typedef logic [3:0] strb_t;

    // target of one bus request
    typedef enum logic [2:0] {
        DEV_NONE,
        DEV_BRAM,
        DEV_UART,
        DEV_TIMER,
        DEV_FREQ
    } dev_sel_e;

endpackage

// ==== design/soc_settings.svh ====
////////////////////////////////////////////////////////////
// system constants shared by the decoder, devices and testbench
// BAUD_DIV and TICK_DIV must be at least 2
////////////////////////////////////////////////////////////
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// clock in Hz, also read back from the frequency register
`define SYSTEM_CLK 32'd25_000_000

// block RAM depth in 32-bit words
`define BRAM_WORDS 256

// uart registers
`define UART_TX_ADDR 32'h1000_0000
`define UART_RX_ADDR 32'h1000_0004
`define UART_LSR_ADDR 32'h1000_0008

// timer block, four word registers from here
`define TIMER_BASE 32'h1100_0000
`define CPU_FREQ_ADDR 32'h1200_0000

// clocks per uart bit and per mtime increment
`define BAUD_DIV 8
`define TICK_DIV 4

`endif

// ==== design/uart_port.sv ====
////////////////////////////////////////////////////////////
// uart registers TX, RX and LSR, a TX write while busy is lost
////////////////////////////////////////////////////////////
`include "soc_settings.svh"

module uart_port (
    input  logic      clk,
    input  logic      resetn,
    mem_bus_if.device bus,
    input  logic      uart_rx,
    output logic      uart_tx
);

    logic       wr;
    logic       tx_busy;
    logic       tx_start;
    logic       rx_take;
    logic [7:0] rx_data;
    logic       rx_held;

    assign wr = |bus.wstrb;

    // only an idle transmitter accepts a byte
    assign tx_start = bus.valid && wr && bus.addr == `UART_TX_ADDR && !tx_busy;
    // reading RX pops the holding byte
    assign rx_take = bus.valid && !wr && bus.addr == `UART_RX_ADDR;

    uart_tx u_tx (
        .clk   (clk),
        .resetn(resetn),
        .start (tx_start),
        .data  (bus.wdata[7:0]),
        .line  (uart_tx),
        .busy  (tx_busy)
    );

    uart_rx u_rx (
        .clk   (clk),
        .resetn(resetn),
        .line  (uart_rx),
        .take  (rx_take),
        .data  (rx_data),
        .held  (rx_held)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.valid) begin
            if (bus.addr == `UART_RX_ADDR) begin
                bus.rdata <= rx_held ? {24'b0, rx_data} : '1;
            end else if (bus.addr == `UART_LSR_ADDR) begin
                // bit 0 byte held, bits 5 and 6 transmitter idle
                bus.rdata <= {25'b0, !tx_busy, !tx_busy, 4'b0, rx_held};
            end else begin
                bus.rdata <= '0;
            end
        end
    end

endmodule

// ==== design/uart_rx.sv ====
////////////////////////////////////////////////////////////
// 8N1 receiver with one holding byte, a new byte overwrites
////////////////////////////////////////////////////////////
`include "soc_settings.svh"

module uart_rx (
    input  logic       clk,
    input  logic       resetn,
    input  logic       line,
    input  logic       take,
    output logic [7:0] data,
    output logic       held
);

    localparam int CW = $clog2(`BAUD_DIV);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e     state;
    logic [1:0]    sync;
    logic [CW-1:0] baud_cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shreg;
    logic          load;

    // mid stop bit with a high line
    assign load = state == RX_STOP && baud_cnt == '0 && sync[1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= RX_IDLE;
            sync     <= 2'b11;
            baud_cnt <= '0;
            bit_idx  <= '0;
            held     <= 1'b0;
        end else begin
            sync <= {sync[0], line};
            if (load) begin
                held <= 1'b1;
            end else if (take) begin
                held <= 1'b0;
            end
            if (state != RX_IDLE && baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                case (state)
                    RX_IDLE: begin
                        if (!sync[1]) begin
                            state    <= RX_START;
                            baud_cnt <= CW'(`BAUD_DIV / 2 - 1);
                        end
                    end
                    RX_START: begin
                        // glitch shorter than half a bit goes back to idle
                        state    <= sync[1] ? RX_IDLE : RX_DATA;
                        baud_cnt <= CW'(`BAUD_DIV - 1);
                        bit_idx  <= '0;
                    end
                    RX_DATA: begin
                        baud_cnt <= CW'(`BAUD_DIV - 1);
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // sample shift and holding byte
    always_ff @(posedge clk) begin
        if (state == RX_DATA && baud_cnt == '0) begin
            shreg <= {sync[1], shreg[7:1]};
        end
        if (load) begin
            data <= shreg;
        end
    end

endmodule

// ==== design/uart_tx.sv ====
////////////////////////////////////////////////////////////
// 8N1 transmitter, start must only come while idle
////////////////////////////////////////////////////////////
`include "soc_settings.svh"

module uart_tx (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  logic [7:0] data,
    output logic       line,
    output logic       busy
);

    localparam int CW = $clog2(`BAUD_DIV);

    logic [CW-1:0] baud_cnt;
    logic [3:0]    bit_cnt;
    // stop, data lsb first, start
    logic [9:0]    frame;

    assign line = frame[0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            frame    <= '1;
        end else if (start) begin
            busy     <= 1'b1;
            baud_cnt <= CW'(`BAUD_DIV - 1);
            bit_cnt  <= 4'd9;
            frame    <= {1'b1, data, 1'b0};
        end else if (busy) begin
            if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else if (bit_cnt == '0) begin
                // end of stop bit
                busy <= 1'b0;
            end else begin
                baud_cnt <= CW'(`BAUD_DIV - 1);
                bit_cnt  <= bit_cnt - 1'b1;
                frame    <= {1'b1, frame[9:1]};
            end
        end
    end

    a_start_when_idle : assert property (@(posedge clk) disable iff (!resetn)
        start |-> !busy);

endmodule

// ==== soc_io_top.f ====
+incdir+design
design/soc_pkg.sv
design/mem_bus_if.sv
design/bus_decoder.sv
design/bram_store.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_port.sv
design/core_timer.sv
design/soc_io_top.sv
test/tb_soc_io.sv

// ==== test/tb_soc_io.sv ====
////////////////////////////////////////////////////////////
// drives soc_io_top as the bus host, uart_tx looped to uart_rx
// the first mismatch ends the run
////////////////////////////////////////////////////////////
`include "soc_settings.svh"

module tb_soc_io;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_BRAM   = 200;
    localparam int N_FAULT  = 20;
    localparam int N_BYTES  = 16;
    // fill, random writes, read back, faults, uart, timer
    localparam int N_ACCESS = `BRAM_WORDS * 2 + N_BRAM + 2 * N_FAULT + 4 * N_BYTES + 16;
    localparam int TIMEOUT  = N_ACCESS * 4 + N_BYTES * 12 * `BAUD_DIV + 2000;

    logic           clk;
    logic           resetn;
    logic           mem_valid;
    soc_pkg::word_t mem_addr;
    soc_pkg::word_t mem_wdata;
    soc_pkg::strb_t mem_wstrb;
    logic           mem_ready;
    soc_pkg::word_t mem_rdata;
    logic           access_fault;
    logic           uart_tx;
    logic           uart_rx;
    logic           timer_irq;

    integer         seed = 32'hba66_7bc3;
    int             cycle_count = 0;

    // reference model
    soc_pkg::word_t model_mem [`BRAM_WORDS];
    bit             touched [`BRAM_WORDS];
    logic [7:0]     expected_byte;

    soc_io_top dut (
        .clk         (clk),
        .resetn      (resetn),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .access_fault(access_fault),
        .uart_rx     (uart_rx),
        .uart_tx     (uart_tx),
        .timer_irq   (timer_irq)
    );

    // loopback, idle high until the transmitter leaves reset
    assign uart_rx = (uart_tx === 1'b0) ? 1'b0 : 1'b1;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout: test still running after %0d cycles at %0t", cycle_count, $time);
            $display("TB FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    ////////////////////////////////////////////////////////////
    // checks and bus tasks

    task automatic check_equal(input soc_pkg::word_t got, input soc_pkg::word_t exp,
                               input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("TB FAILED");
            $fatal(1, "check mismatch");
        end
    endtask

    // one request held until ready, ready must come one cycle after valid
    task automatic bus_access(input soc_pkg::word_t addr, input soc_pkg::word_t wdata,
                              input soc_pkg::strb_t wstrb, input logic exp_fault,
                              output soc_pkg::word_t rdata);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        mem_valid = 1'b1;
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_wstrb = wstrb;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (mem_ready !== 1'b1);
        check_equal(cycles, 1, "cycles from valid to ready");
        check_equal(access_fault, exp_fault, "access_fault with ready");
        rdata     = mem_rdata;
        mem_valid = 1'b0;
    endtask

    task automatic write_word(input soc_pkg::word_t addr, input soc_pkg::word_t data,
                              input soc_pkg::strb_t strb);
        soc_pkg::word_t old_word;
        bus_access(addr, data, strb, 1'b0, old_word);
    endtask

    task automatic read_word(input soc_pkg::word_t addr, output soc_pkg::word_t data);
        bus_access(addr, '0, '0, 1'b0, data);
    endtask

    // memory map regions
    function automatic logic is_mapped(input soc_pkg::word_t addr);
        return addr < `BRAM_WORDS * 4 || addr == `UART_TX_ADDR || addr == `UART_RX_ADDR ||
               addr == `UART_LSR_ADDR || addr == `CPU_FREQ_ADDR ||
               (addr >= `TIMER_BASE && addr < `TIMER_BASE + 16);
    endfunction

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        soc_pkg::word_t r;
        soc_pkg::word_t rd;
        soc_pkg::word_t addr;
        soc_pkg::word_t t0;
        soc_pkg::strb_t strb;
        int             idx;
        int             t0_cycle;
        int             delta;
        int             lo;
        int             hi;
        int             waited;

        resetn    = 1'b0;
        mem_valid = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
        check_equal(mem_ready, 0, "mem_ready after reset");
        check_equal(access_fault, 0, "access_fault after reset");
        check_equal(uart_tx, 1, "uart_tx idle after reset");
        check_equal(timer_irq, 0, "timer_irq after reset");

        // known contents first, pattern spread over the whole address
        for (int i = 0; i < `BRAM_WORDS; i++) begin
            addr         = 32'(i * 4);
            model_mem[i] = (addr * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
            write_word(addr, model_mem[i], 4'hf);
        end

        // random byte-strobed writes
        for (int i = 0; i < N_BRAM; i++) begin
            r    = $random(seed);
            idx  = int'(r % `BRAM_WORDS);
            strb = 4'($random(seed));
            while (strb == 4'b0000) begin
                strb = 4'($random(seed));
            end
            r = $random(seed);
            // a write replies with the word it replaces
            bus_access(32'(idx * 4), r, strb, 1'b0, rd);
            check_equal(rd, model_mem[idx], "bram old word returned by write");
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model_mem[idx][8*b +: 8] = r[8*b +: 8];
                end
            end
            touched[idx] = 1'b1;
        end
        for (int i = 0; i < `BRAM_WORDS; i++) begin
            if (touched[i]) begin
                read_word(32'(i * 4), rd);
                check_equal(rd, model_mem[i], "bram word after random writes");
            end
        end

        read_word(`CPU_FREQ_ADDR, rd);
        check_equal(rd, `SYSTEM_CLK, "frequency register");

        // unmapped space answers zero with a fault
        for (int i = 0; i < N_FAULT; i++) begin
            addr = $random(seed);
            while (is_mapped(addr)) begin
                addr = $random(seed);
            end
            r    = $random(seed);
            strb = 4'($random(seed)) | 4'b0001;
            bus_access(addr, r, strb, 1'b1, rd);
            check_equal(rd, 0, "unmapped write reply");
            bus_access(addr, '0, '0, 1'b1, rd);
            check_equal(rd, 0, "unmapped read reply");
        end

        ////////////////////////////////////////////////////////////
        // uart loopback
        for (int i = 0; i < N_BYTES; i++) begin
            expected_byte = 8'($random(seed));
            rd = '0;
            while ((rd & 32'h60) !== 32'h60) begin
                read_word(`UART_LSR_ADDR, rd);
            end
            write_word(`UART_TX_ADDR, 32'(expected_byte), 4'b0001);
            rd = '0;
            while (rd[0] !== 1'b1) begin
                read_word(`UART_LSR_ADDR, rd);
            end
            read_word(`UART_RX_ADDR, rd);
            check_equal(rd, 32'(expected_byte), "uart loopback byte");
            read_word(`UART_LSR_ADDR, rd);
            check_equal(rd & 32'h1, 0, "lsr bit 0 after rx read");
            read_word(`UART_RX_ADDR, rd);
            check_equal(rd, 32'hffff_ffff, "rx read with nothing held");
        end

        ////////////////////////////////////////////////////////////
        // timer
        read_word(`TIMER_BASE, t0);
        t0_cycle = cycle_count;
        repeat (40) @(posedge clk);
        read_word(`TIMER_BASE, rd);
        delta = cycle_count - t0_cycle;
        lo    = delta / `TICK_DIV;
        hi    = (delta + `TICK_DIV - 1) / `TICK_DIV;
        // advance must lie between floor and ceiling of cycles per tick
        check_equal(32'((rd - t0) >= lo && (rd - t0) <= hi), 1,
                    "mtime advance between reads");

        read_word(`TIMER_BASE, t0);
        write_word(`TIMER_BASE + 12, 32'h0, 4'hf);
        write_word(`TIMER_BASE + 8, t0 + 50, 4'hf);
        check_equal(timer_irq, 0, "timer_irq right after mtimecmp write");
        waited = 0;
        while (timer_irq !== 1'b1 && waited < 50 * `TICK_DIV + 10) begin
            @(posedge clk);
            #1;
            waited++;
        end
        check_equal(timer_irq, 1, "timer_irq once mtime reaches mtimecmp");

        write_word(`TIMER_BASE + 12, 32'hffff_ffff, 4'hf);
        write_word(`TIMER_BASE + 8, 32'hffff_ffff, 4'hf);
        check_equal(timer_irq, 0, "timer_irq with mtimecmp all ones");
        read_word(`TIMER_BASE + 8, rd);
        check_equal(rd, 32'hffff_ffff, "mtimecmp low readback");
        read_word(`TIMER_BASE + 12, rd);
        check_equal(rd, 32'hffff_ffff, "mtimecmp high readback");

        $display("TB PASSED");
        $finish;
    end

endmodule
